// File: src/tetris_pkg.sv
package tetris_pkg;

  // Board geometry in cells
  localparam int GRID_COLS = 10;
  localparam int GRID_ROWS = 20;

  localparam int SCORE_W = 8;  // Also the width of the right LED bank

  // Bit order is {red, green, blue}
  typedef enum logic [2:0] {
    BLACK   = 3'b000,
    RED     = 3'b100,
    GREEN   = 3'b010,
    BLUE    = 3'b001,
    YELLOW  = 3'b110,
    MAGENTA = 3'b101,
    CYAN    = 3'b011,
    WHITE   = 3'b111
  } color_t;

  typedef enum logic [2:0] {
    IDLE,
    SPAWN,
    FALL,
    LOCK,
    CLEAR,
    OVER
  } game_state_t;

  typedef enum logic {
    PIECE_I,  // Four in a line
    PIECE_O   // Two by two
  } piece_t;

endpackage

// File: src/vga_timing.sv
`timescale 1ns/10ps

module vga_timing #(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic       hz100,
  input  logic       reset,
  output logic [9:0] x,
  output logic [9:0] y,
  output logic       active,
  output logic       hsync,
  output logic       vsync
);
  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int VS_START = V_ACTIVE + V_FRONT;

  logic [9:0] x_next;
  logic [9:0] y_next;
  logic       line_end;

  assign line_end = (x == 10'(H_TOTAL - 1));
  assign x_next   = line_end ? 10'd0 : x + 10'd1;

  always_comb begin
    y_next = y;
    if (line_end) begin
      y_next = (y == 10'(V_TOTAL - 1)) ? 10'd0 : y + 10'd1;
    end
  end

  // Syncs are decoded from the next count so they line up with x and y
  always_ff @(posedge hz100, posedge reset) begin
    if (reset) begin
      x     <= '0;
      y     <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      x     <= x_next;
      y     <= y_next;
      hsync <= !(x_next >= HS_START && x_next < HS_START + H_SYNC);
      vsync <= !(y_next >= VS_START && y_next < VS_START + V_SYNC);  // Whole lines
    end
  end

  assign active = (x < H_ACTIVE) && (y < V_ACTIVE);

  a_x_in_line: assert property (@(posedge hz100) disable iff (reset) x < 10'(H_TOTAL))
    else $error("vga_timing: x ran past the line total");

endmodule

// File: src/drop_timer.sv
`timescale 1ns/10ps

module drop_timer #(
  parameter int DROP_BASE = 10_000_000,
  parameter int DROP_STEP = 1_000_000,
  parameter int DROP_MIN  = 2_000_000
) (
  input  logic                           hz100,
  input  logic                           reset,
  input  logic [tetris_pkg::SCORE_W-1:0] score,
  input  logic                           game_over,
  output logic                           tick
);
  logic [31:0]                    count;
  logic [31:0]                    period;
  logic [tetris_pkg::SCORE_W-1:0] level;
  logic [tetris_pkg::SCORE_W-1:0] prev_score;
  logic                           raised;  // Speed-up already taken at this multiple
  logic                           score_moved;
  logic                           at_multiple;

  always_comb begin
    int p;
    p = DROP_BASE - DROP_STEP * int'(level);
    if (p < DROP_MIN) begin
      p = DROP_MIN;  // Floor on gravity speed
    end
    period = 32'(p);
  end

  assign score_moved = (score != prev_score);
  assign at_multiple = (score % 5 == 0) && (score != '0);

  always_ff @(posedge hz100, posedge reset) begin
    if (reset) begin
      count      <= '0;
      tick       <= 1'b0;
      level      <= '0;
      raised     <= 1'b0;
      prev_score <= '0;
    end else begin
      prev_score <= score;
      tick       <= 1'b0;
      if (game_over) begin
        count  <= '0;
        level  <= '0;
        raised <= 1'b0;
      end else begin
        if (count == '0) begin
          tick  <= 1'b1;
          count <= period - 32'd1;  // Reload with the current period
        end else begin
          count <= count - 32'd1;
        end
        if (score_moved && at_multiple && !raised) begin
          level  <= level + 1'b1;
          raised <= 1'b1;
        end else if (score_moved && !at_multiple) begin
          raised <= 1'b0;  // Left the multiple, next one counts again
        end
      end
    end
  end

  a_tick_single: assert property (@(posedge hz100) disable iff (reset) tick |=> !tick)
    else $error("drop_timer: tick held for two cycles");

endmodule

// File: src/tetris_fsm.sv
`timescale 1ns/10ps

module tetris_fsm (
  input  logic                           hz100,
  input  logic                           reset,
  input  logic                           tick,
  input  logic                           move_left,
  input  logic                           move_right,
  input  logic                           rotate,
  input  logic                           start,
  output logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0]       board_cells,
  output logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0]       board_piece,
  output logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0][1:0]  fall_cells,
  output logic [tetris_pkg::SCORE_W-1:0] score,
  output logic                           game_over,
  output logic                           playing
);
  localparam int ROWS = tetris_pkg::GRID_ROWS;
  localparam int COLS = tetris_pkg::GRID_COLS;

  tetris_pkg::game_state_t state;
  tetris_pkg::piece_t      piece;
  tetris_pkg::piece_t      next_piece;
  logic                    vert;       // I bar standing up
  logic signed [5:0]       pr;         // Origin row, top left of the piece
  logic signed [5:0]       pc;         // Origin column
  logic [3:0]              btn_sync1;
  logic [3:0]              btn_sync2;
  logic [3:0]              btn_prev;
  logic [3:0]              edges;      // {start, rotate, right, left}
  logic [4:0]              ptr;        // Row under test in CLEAR
  logic [4:0]              cnt;
  logic signed [5:0]       mc;
  logic                    mv;
  logic                    down_ok;
  logic                    spawn_ok;
  logic signed [5:0]       spawn_col;
  logic [ROWS-1:0][COLS-1:0] fall_mask;

  function automatic logic [ROWS-1:0][COLS-1:0] cell_mask(input int r, input int c,
                                                          input tetris_pkg::piece_t p,
                                                          input logic v);
    logic [ROWS-1:0][COLS-1:0] m;
    int rr;
    int cc;
    m = '0;
    for (int i = 0; i < 4; i++) begin
      if (p == tetris_pkg::PIECE_O) begin
        rr = r + i / 2;
        cc = c + i % 2;
      end else if (v) begin
        rr = r + i;
        cc = c;
      end else begin
        rr = r;
        cc = c + i;
      end
      if (rr >= 0 && rr < ROWS && cc >= 0 && cc < COLS) begin
        m[rr][cc] = 1'b1;
      end
    end
    return m;
  endfunction

  // All four cells inside the walls and none on an occupied cell
  function automatic logic fits(input int r, input int c, input tetris_pkg::piece_t p,
                                input logic v, input logic [ROWS-1:0][COLS-1:0] b);
    logic [ROWS-1:0][COLS-1:0] m;
    m = cell_mask(r, c, p, v);
    return ($countones(m) == 4) && ((m & b) == '0);
  endfunction

  always_ff @(posedge hz100, posedge reset) begin
    if (reset) begin
      btn_sync1 <= '0;
      btn_sync2 <= '0;
      btn_prev  <= '0;
    end else begin
      btn_sync1 <= {start, rotate, move_right, move_left};
      btn_sync2 <= btn_sync1;
      btn_prev  <= btn_sync2;
    end
  end

  assign edges = btn_sync2 & ~btn_prev;

  // Sideways moves and rotation first, then gravity from the moved spot
  always_comb begin
    int   r;
    int   c;
    logic v;
    r = int'(pr);
    c = int'(pc);
    v = vert;
    if (edges[0] && fits(r, c - 1, piece, v, board_cells)) begin
      c = c - 1;
    end
    if (edges[1] && fits(r, c + 1, piece, v, board_cells)) begin
      c = c + 1;
    end
    if (edges[2] && piece == tetris_pkg::PIECE_I && fits(r, c, piece, !v, board_cells)) begin
      v = !v;
    end
    mc      = 6'(c);
    mv      = v;
    down_ok = fits(r + 1, c, piece, v, board_cells);
  end

  assign spawn_col = (next_piece == tetris_pkg::PIECE_I) ? 6'sd3 : 6'sd4;
  assign spawn_ok  = fits(0, int'(spawn_col), next_piece, 1'b0, board_cells);
  assign fall_mask = cell_mask(int'(pr), int'(pc), piece, vert);

  always_comb begin
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        fall_cells[r][c] = {fall_mask[r][c] && (state == tetris_pkg::FALL ||
                                                state == tetris_pkg::LOCK), piece};
      end
    end
  end

  always_ff @(posedge hz100, posedge reset) begin
    if (reset) begin
      state       <= tetris_pkg::IDLE;
      piece       <= tetris_pkg::PIECE_I;
      next_piece  <= tetris_pkg::PIECE_I;
      vert        <= 1'b0;
      pr          <= '0;
      pc          <= '0;
      score       <= '0;
      board_cells <= '0;
      board_piece <= '0;
      ptr         <= '0;
      cnt         <= '0;
    end else begin
      case (state)
        tetris_pkg::IDLE, tetris_pkg::OVER: begin
          if (edges[3]) begin
            board_cells <= '0;
            board_piece <= '0;
            score       <= '0;
            next_piece  <= tetris_pkg::PIECE_I;
            state       <= tetris_pkg::SPAWN;
          end
        end
        tetris_pkg::SPAWN: begin
          piece <= next_piece;
          pr    <= '0;
          pc    <= spawn_col;
          vert  <= 1'b0;
          if (spawn_ok) begin
            next_piece <= (next_piece == tetris_pkg::PIECE_I) ? tetris_pkg::PIECE_O
                                                               : tetris_pkg::PIECE_I;
            state      <= tetris_pkg::FALL;
          end else begin
            state <= tetris_pkg::OVER;  // Stack reached the spawn rows
          end
        end
        tetris_pkg::FALL: begin
          pc   <= mc;
          vert <= mv;
          if (tick) begin
            if (down_ok) begin
              pr <= pr + 6'sd1;
            end else begin
              state <= tetris_pkg::LOCK;
            end
          end
        end
        tetris_pkg::LOCK: begin
          board_cells <= board_cells | fall_mask;
          for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
              if (fall_mask[r][c]) begin
                board_piece[r][c] <= piece;
              end
            end
          end
          ptr   <= 5'(ROWS - 1);
          cnt   <= '0;
          state <= tetris_pkg::CLEAR;
        end
        tetris_pkg::CLEAR: begin
          if (&board_cells[ptr]) begin
            score <= score + 1'b1;
            // Pointer stays put, the row dropped in gets tested next
            for (int r = ROWS - 1; r > 0; r--) begin
              if (r <= ptr) begin
                board_cells[r] <= board_cells[r-1];
                board_piece[r] <= board_piece[r-1];
              end
            end
            board_cells[0] <= '0;
            board_piece[0] <= '0;
          end else begin
            ptr <= ptr - 1'b1;
          end
          cnt <= cnt + 1'b1;
          if (cnt == 5'(ROWS - 1)) begin
            state <= tetris_pkg::SPAWN;
          end
        end
        default: state <= tetris_pkg::IDLE;
      endcase
    end
  end

  assign game_over = (state == tetris_pkg::OVER);
  assign playing   = (state != tetris_pkg::IDLE) && (state != tetris_pkg::OVER);

  a_score_source: assert property (@(posedge hz100) disable iff (reset)
    (score != $past(score)) |-> ($past(state) == tetris_pkg::CLEAR || $past(edges[3])))
    else $error("tetris_fsm: score changed outside CLEAR or start");

  a_no_overlap: assert property (@(posedge hz100) disable iff (reset)
    (state == tetris_pkg::FALL) |-> ((fall_mask & board_cells) == '0))
    else $error("tetris_fsm: falling piece overlaps the board");

endmodule

// File: src/grid_render.sv
`timescale 1ns/10ps

module grid_render #(
  parameter int CELL_PX = 16
) (
  input  logic [9:0] x,
  input  logic [9:0] y,
  input  logic       active,
  input  logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0]      board_cells,
  input  logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0]      board_piece,
  input  logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0][1:0] fall_cells,
  input  logic       game_over,
  output tetris_pkg::color_t board_color
);
  localparam int X0 = CELL_PX;      // Playfield top left in pixels
  localparam int Y0 = 2 * CELL_PX;
  localparam int X1 = X0 + tetris_pkg::GRID_COLS * CELL_PX;
  localparam int Y1 = Y0 + tetris_pkg::GRID_ROWS * CELL_PX;

  function automatic tetris_pkg::color_t piece_color(input logic p);
    return (p == tetris_pkg::PIECE_O) ? tetris_pkg::YELLOW : tetris_pkg::CYAN;
  endfunction

  always_comb begin
    logic [4:0] row;
    logic [3:0] col;
    logic       in_field;
    logic       in_frame;
    row      = 5'((int'(y) - Y0) / CELL_PX);
    col      = 4'((int'(x) - X0) / CELL_PX);
    in_field = (x >= X0) && (x < X1) && (y >= Y0) && (y < Y1);
    in_frame = (x >= X0 - CELL_PX) && (x < X1 + CELL_PX) &&
               (y >= Y0 - CELL_PX) && (y < Y1 + CELL_PX);  // Field plus one cell
    board_color = tetris_pkg::BLACK;
    if (active) begin
      if (in_field) begin
        if (board_cells[row][col]) begin
          board_color = game_over ? tetris_pkg::RED : piece_color(board_piece[row][col]);
        end else if (fall_cells[row][col][1]) begin
          board_color = piece_color(fall_cells[row][col][0]);
        end
      end else if (in_frame) begin
        board_color = tetris_pkg::WHITE;  // Border ring
      end
    end
  end

endmodule

// File: src/score_overlay.sv
`timescale 1ns/10ps

module score_overlay #(
  parameter int CELL_PX = 16
) (
  input  logic [9:0]                     x,
  input  logic [9:0]                     y,
  input  logic                           active,
  input  logic [tetris_pkg::SCORE_W-1:0] score,
  input  tetris_pkg::color_t             board_color,
  output tetris_pkg::color_t             pixel_color
);
  localparam int X0    = CELL_PX;  // Squares line up with the playfield
  localparam int X1    = X0 + tetris_pkg::SCORE_W * CELL_PX;
  localparam int IDX_W = $clog2(tetris_pkg::SCORE_W);

  always_comb begin
    int               slot;
    logic [IDX_W-1:0] idx;
    slot = (int'(x) - X0) / CELL_PX;
    idx  = IDX_W'(tetris_pkg::SCORE_W - 1 - slot);  // MSB on the left
    pixel_color = board_color;
    if (active && (y < CELL_PX) && (x >= X0) && (x < X1)) begin
      // Score square wins over the board
      pixel_color = score[idx] ? tetris_pkg::GREEN : tetris_pkg::BLUE;
    end
  end

endmodule

// File: src/tetris_top.sv
`timescale 1ns/10ps

module tetris_top #(
  parameter int H_ACTIVE  = 640,
  parameter int H_FRONT   = 16,
  parameter int H_SYNC    = 96,
  parameter int H_BACK    = 48,
  parameter int V_ACTIVE  = 480,
  parameter int V_FRONT   = 10,
  parameter int V_SYNC    = 2,
  parameter int V_BACK    = 33,
  parameter int CELL_PX   = 16,
  parameter int DROP_BASE = 10_000_000,
  parameter int DROP_STEP = 1_000_000,
  parameter int DROP_MIN  = 2_000_000
) (
  input  logic        hz100,
  input  logic        reset,
  input  logic [20:0] pb,
  output logic [7:0]  left,
  output logic [7:0]  right,
  output logic        red,
  output logic        green,
  output logic        blue
);
  logic [9:0] x;
  logic [9:0] y;
  logic       active;
  logic       hsync;
  logic       vsync;
  logic       tick;
  logic       game_over;
  logic       playing;
  logic [tetris_pkg::SCORE_W-1:0] score;
  logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0]      board_cells;
  logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0]      board_piece;
  logic [tetris_pkg::GRID_ROWS-1:0][tetris_pkg::GRID_COLS-1:0][1:0] fall_cells;
  tetris_pkg::color_t board_color;
  tetris_pkg::color_t pixel_color;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
  ) vga_timing_i (
    .hz100(hz100), .reset(reset), .x(x), .y(y), .active(active),
    .hsync(hsync), .vsync(vsync)
  );

  drop_timer #(
    .DROP_BASE(DROP_BASE), .DROP_STEP(DROP_STEP), .DROP_MIN(DROP_MIN)
  ) drop_timer_i (
    .hz100(hz100), .reset(reset), .score(score), .game_over(game_over), .tick(tick)
  );

  tetris_fsm tetris_fsm_i (
    .hz100(hz100), .reset(reset), .tick(tick),
    .move_left(pb[11]), .move_right(pb[8]), .rotate(pb[7]), .start(pb[19]),
    .board_cells(board_cells), .board_piece(board_piece), .fall_cells(fall_cells),
    .score(score), .game_over(game_over), .playing(playing)
  );

  grid_render #(.CELL_PX(CELL_PX)) grid_render_i (
    .x(x), .y(y), .active(active), .board_cells(board_cells), .board_piece(board_piece),
    .fall_cells(fall_cells), .game_over(game_over), .board_color(board_color)
  );

  score_overlay #(.CELL_PX(CELL_PX)) score_overlay_i (
    .x(x), .y(y), .active(active), .score(score), .board_color(board_color),
    .pixel_color(pixel_color)
  );

  assign left[7]   = hsync;
  assign left[6]   = vsync;
  assign left[5:3] = pixel_color;  // {R, G, B} to the VGA pins
  assign left[2:0] = 3'b000;
  assign right     = score;
  assign red       = game_over;
  assign green     = playing;
  assign blue      = !(game_over || playing);  // Idle

endmodule

// File: verification/tetris_tb.sv
`timescale 1ns/10ps

module tetris_tb;

  localparam int H_ACTIVE  = 32;
  localparam int H_FRONT   = 2;
  localparam int H_SYNC    = 4;
  localparam int H_BACK    = 2;
  localparam int V_ACTIVE  = 48;
  localparam int V_FRONT   = 2;
  localparam int V_SYNC    = 4;
  localparam int V_BACK    = 2;
  localparam int CELL_PX   = 2;
  localparam int DROP_BASE = 40;
  localparam int H_TOTAL   = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL   = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int ROWS      = tetris_pkg::GRID_ROWS;
  localparam int COLS      = tetris_pkg::GRID_COLS;

  // Test lengths in cycles, worst case
  localparam int LEN_RESET = 16;
  localparam int LEN_CLEAR = 3 * (ROWS + 2) * DROP_BASE;
  localparam int LEN_OVER  = ROWS * (ROWS + 2) * DROP_BASE;  // At most one piece per row
  localparam int LEN_TAIL  = 2 * H_TOTAL * V_TOTAL;
  localparam int TIMEOUT   = 4 * (LEN_RESET + LEN_CLEAR + LEN_OVER + LEN_TAIL);

  logic        hz100;
  logic        reset;
  logic [20:0] pb;
  logic [7:0]  left;
  logic [7:0]  right;
  logic        red;
  logic        green;
  logic        blue;
  logic        hsync;
  logic        vsync;
  logic [7:0]  right_q;     // Score LEDs one cycle back
  int          seed;
  int          cycles;
  int          errs [1:6];
  logic        started;
  logic        expect_one;  // Bottom row cleared, score must read 1
  logic        restarted;
  int          tx;          // Raster position rebuilt from the syncs
  int          ty;
  logic        x_locked;
  logic        y_locked;
  logic        hs_prev;
  logic        vs_prev;
  int          hs_low;
  int          hs_gap;
  int          vs_low;
  int          vs_gap;
  logic        hs_seen;
  logic        vs_seen;
  logic        locked;
  logic        in_score_square;
  logic        in_border;
  logic        score_bit;

  tetris_top #(
    .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
    .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
    .CELL_PX(CELL_PX), .DROP_BASE(DROP_BASE), .DROP_STEP(4), .DROP_MIN(16)
  ) tetris_top_i (
    .hz100(hz100), .reset(reset), .pb(pb), .left(left), .right(right),
    .red(red), .green(green), .blue(blue)
  );

  assign hsync = left[7];
  assign vsync = left[6];

  function automatic logic score_bit_at(input int px, input logic [7:0] s);
    int slot;
    slot = (px - CELL_PX) / CELL_PX;
    if (slot < 0 || slot > tetris_pkg::SCORE_W - 1) begin
      return 1'b0;
    end
    return s[tetris_pkg::SCORE_W - 1 - slot];  // MSB leftmost
  endfunction

  assign locked          = x_locked && y_locked;
  assign in_score_square = locked && ty < CELL_PX && tx >= CELL_PX && tx < 9 * CELL_PX;
  assign in_border       = locked && ty >= 2 * CELL_PX && ty < (ROWS + 2) * CELL_PX &&
                           (tx < CELL_PX || (tx >= (COLS + 1) * CELL_PX &&
                                             tx < (COLS + 2) * CELL_PX));
  assign score_bit       = score_bit_at(tx, right);

  initial begin
    hz100 = 1'b0;
    forever #10 hz100 = ~hz100;
  end

  // Sync pulse widths and spacing, plus x and y for the pixel model
  always @(posedge hz100) begin
    hs_prev <= hsync;
    vs_prev <= vsync;
    right_q <= right;
    hs_low  <= hsync ? 0 : hs_low + 1;
    vs_low  <= vsync ? 0 : vs_low + 1;
    if (reset) begin
      tx       <= 0;
      ty       <= 0;
      x_locked <= 1'b0;
      y_locked <= 1'b0;
      hs_gap   <= 0;
      vs_gap   <= 0;
      hs_seen  <= 1'b0;
      vs_seen  <= 1'b0;
    end else begin
      hs_gap <= (hs_prev && !hsync) ? 1 : hs_gap + 1;
      vs_gap <= (vs_prev && !vsync) ? 1 : vs_gap + 1;
      if (hs_prev && !hsync) begin
        tx       <= H_ACTIVE + H_FRONT + 1;  // Fall marks x = H_ACTIVE + H_FRONT
        x_locked <= 1'b1;
        hs_seen  <= 1'b1;
      end else begin
        tx <= (tx == H_TOTAL - 1) ? 0 : tx + 1;
      end
      if (vs_prev && !vsync) begin
        ty       <= V_ACTIVE + V_FRONT;
        y_locked <= 1'b1;
        vs_seen  <= 1'b1;
      end else if (tx == H_TOTAL - 1) begin
        ty <= (ty == V_TOTAL - 1) ? 0 : ty + 1;
      end
    end
  end

  a_reset_syncs: assert property (@(posedge hz100) cycles > 1 && reset |-> hsync && vsync)
    else begin
      errs[1]++;
      $display("Fail %0t: hsync/vsync expected 1/1 got %b/%b", $time,
               $sampled(hsync), $sampled(vsync));
    end

  a_idle_leds: assert property (@(posedge hz100)
    cycles > 1 && !started |-> right == 8'd0 && !red && !green && blue)
    else begin
      errs[1]++;
      $display("Fail %0t: idle LEDs expected right=0 r=0 g=0 b=1 got right=%0d r=%b g=%b b=%b",
               $time, $sampled(right), $sampled(red), $sampled(green), $sampled(blue));
    end

  a_hsync_width: assert property (@(posedge hz100) disable iff (reset)
    $rose(hsync) |-> hs_low == H_SYNC)
    else begin
      errs[2]++;
      $display("Fail %0t: hsync low cycles expected %0d got %0d", $time, H_SYNC, $sampled(hs_low));
    end

  a_hsync_period: assert property (@(posedge hz100) disable iff (reset)
    $fell(hsync) && hs_seen |-> hs_gap == H_TOTAL)
    else begin
      errs[2]++;
      $display("Fail %0t: hsync period expected %0d got %0d", $time, H_TOTAL, $sampled(hs_gap));
    end

  a_vsync_width: assert property (@(posedge hz100) disable iff (reset)
    $rose(vsync) |-> vs_low == V_SYNC * H_TOTAL)
    else begin
      errs[2]++;
      $display("Fail %0t: vsync low cycles expected %0d got %0d", $time, V_SYNC * H_TOTAL,
               $sampled(vs_low));
    end

  a_vsync_period: assert property (@(posedge hz100) disable iff (reset)
    $fell(vsync) && vs_seen |-> vs_gap == V_TOTAL * H_TOTAL)
    else begin
      errs[2]++;
      $display("Fail %0t: vsync period expected %0d got %0d", $time, V_TOTAL * H_TOTAL,
               $sampled(vs_gap));
    end

  a_score_step: assert property (@(posedge hz100) disable iff (reset)
    started && !restarted && $changed(right) |-> right == 8'd1)
    else begin
      errs[3]++;
      $display("Fail %0t: right expected 1 got %0d", $time, $sampled(right));
    end

  a_score_held: assert property (@(posedge hz100) disable iff (reset)
    expect_one && !restarted |-> right == 8'd1)
    else begin
      errs[3]++;
      $display("Fail %0t: right expected 1 got %0d", $time, $sampled(right));
    end

  a_score_pixels: assert property (@(posedge hz100) disable iff (reset)
    in_score_square |-> left[4] == score_bit && left[3] == !score_bit)
    else begin
      errs[4]++;
      $display("Fail %0t: left[4:3] at x=%0d y=%0d expected %b%b got %b", $time, $sampled(tx),
               $sampled(ty), $sampled(score_bit), !$sampled(score_bit), $sampled(left[4:3]));
    end

  a_over_leds: assert property (@(posedge hz100) disable iff (reset)
    $rose(red) |-> !green && !blue)
    else begin
      errs[5]++;
      $display("Fail %0t: green/blue expected 0/0 at game over got %b/%b", $time,
               $sampled(green), $sampled(blue));
    end

  a_over_frozen: assert property (@(posedge hz100) disable iff (reset)
    red |-> right == right_q)
    else begin
      errs[5]++;
      $display("Fail %0t: right during game over expected %0d got %0d", $time,
               $sampled(right_q), $sampled(right));
    end

  a_start_clears: assert property (@(posedge hz100) disable iff (reset)
    $rose(green) |-> right == 8'd0 && !red && !blue)
    else begin
      errs[5]++;
      $display("Fail %0t: right/red/blue expected 0/0/0 at start got %0d/%b/%b", $time,
               $sampled(right), $sampled(red), $sampled(blue));
    end

  a_blanking: assert property (@(posedge hz100) disable iff (reset)
    locked && !(tx < H_ACTIVE && ty < V_ACTIVE) |-> left[5:3] == 3'b000)
    else begin
      errs[6]++;
      $display("Fail %0t: left[5:3] in blanking expected 0 got %0d", $time, $sampled(left[5:3]));
    end

  a_spare_pins: assert property (@(posedge hz100) disable iff (reset)
    left[2:0] == 3'b000)
    else begin
      errs[6]++;
      $display("Fail %0t: left[2:0] expected 0 got %0d", $time, $sampled(left[2:0]));
    end

  a_border: assert property (@(posedge hz100) disable iff (reset)
    in_border |-> left[5:3] == 3'b111)
    else begin
      errs[6]++;
      $display("Fail %0t: left[5:3] on border x=%0d y=%0d expected 7 got %0d", $time,
               $sampled(tx), $sampled(ty), $sampled(left[5:3]));
    end

  task automatic press_button(input int idx);
    int gap;
    gap = 2 + ($unsigned($random(seed)) % 6);  // Random spot in the move window
    repeat (gap) @(negedge hz100);
    pb[idx] = 1'b1;
    repeat (2) @(negedge hz100);
    pb[idx] = 1'b0;
    repeat (3) @(negedge hz100);  // Low long enough for the next edge
  endtask

  task automatic wait_state(input tetris_pkg::game_state_t target);
    while (tetris_top_i.tetris_fsm_i.state != target) begin
      @(negedge hz100);
    end
  endtask

  task automatic report_test(input int n, input string name);
    $display("Test %0d %s: %s (%0d errors)", n, name, (errs[n] == 0) ? "ok" : "FAILED", errs[n]);
  endtask

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT) begin
      @(posedge hz100);
      cycles++;
    end
    $display("Timeout after %0d cycles, the game never reached the awaited state", cycles);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    int failed;
    seed       = 70557;
    pb         = '0;
    reset      = 1'b1;
    started    = 1'b0;
    expect_one = 1'b0;
    restarted  = 1'b0;
    failed     = 0;
    for (int i = 1; i <= 6; i++) begin
      errs[i] = 0;
    end
    repeat (8) @(negedge hz100);
    reset = 1'b0;
    repeat (6) @(negedge hz100);
    report_test(1, "reset state");

    started = 1'b1;
    press_button(19);
    wait_state(tetris_pkg::FALL);
    repeat (3) press_button(11);  // I bar to columns 0..3
    wait_state(tetris_pkg::LOCK);
    wait_state(tetris_pkg::FALL);
    repeat (4) press_button(8);   // O square to columns 8..9
    wait_state(tetris_pkg::LOCK);
    wait_state(tetris_pkg::FALL);
    press_button(8);              // I bar to columns 4..7 fills the row
    wait_state(tetris_pkg::LOCK);
    repeat (ROWS + 2) @(negedge hz100);
    expect_one = 1'b1;
    report_test(3, "row clear and score");

    while (!red) begin
      @(negedge hz100);
    end
    repeat (100) @(negedge hz100);
    restarted = 1'b1;
    press_button(19);
    while (!green) begin
      @(negedge hz100);
    end
    report_test(5, "game over");

    repeat (LEN_TAIL) @(negedge hz100);
    report_test(2, "sync timing");
    report_test(4, "score display");
    report_test(6, "blank and border");
    for (int i = 1; i <= 6; i++) begin
      if (errs[i] != 0) begin
        failed++;
      end
    end
    $display("Tests: %0d passed, %0d failed", 6 - failed, failed);
    if (failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: sources.f
src/tetris_pkg.sv
src/vga_timing.sv
src/drop_timer.sv
src/tetris_fsm.sv
src/grid_render.sv
src/score_overlay.sv
src/tetris_top.sv
verification/tetris_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tetris_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
